//--- dcache.f
+incdir+.
dcacheCpuPkg.sv
dcacheCtrlPkg.sv
wayCtrlIf.sv
cacheWay.sv
lruPolicy.sv
dcacheFsm.sv
dcache.sv
dcache_props.sv
dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

export_include_dirs:
  - .

sources:
  - files:
      - dcacheCpuPkg.sv
      - dcacheCtrlPkg.sv
      - wayCtrlIf.sv
      - cacheWay.sv
      - lruPolicy.sv
      - dcacheFsm.sv
      - dcache.sv
  - target: test
    files:
      - dcache_props.sv
      - dcache_tb.sv

//--- dcache_tb.sv
// testbench for the data cache: clock, reset, memory model, reference model, step table, checks
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_tb;
  import dcacheCpuPkg::*;

  localparam int MemWords  = 1 << (`DC_PA_BITS - 2);
  localparam int KindRead  = 0;
  localparam int KindWrite = 1;
  localparam int KindFlush = 2;

  logic clk = 1'b0;
  logic rst;
  logic reqValid, flushReq, respDone, busy, miss, flushDone;
  memOpT reqOp;
  paddrT reqAdr, lineAdr;
  wordT  reqWriteData, readData;
  logic [`DC_LINE_BITS-1:0] lineWriteData, lineReadData;
  logic fetchLine, writeLine, busAck;

  // memory model and flat reference copy, one entry per word
  wordT memWords [MemWords];
  wordT refWords [MemWords];

  // step table
  string stepName [$];
  int    stepKind [$];
  paddrT stepAdr  [$];
  wordT  stepData [$];
  int    stepMiss [$];

  int ackDelays [64];
  int ackPick = 0;
  int ackLeft, baseWord;
  bit ackArmed;
  int missCount = 0;
  int cycleCount = 0;
  int cycleLimit = 0;
  int passCount = 0;
  int failCount = 0;

  dcache uut (.*);

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////

  // fill depends on every address bit
  function automatic wordT fillWord(input int wordIdx);
    return (32'(wordIdx) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  // answers one line request, busAck 1 to 4 cycles after it is first seen
  always @(posedge clk) begin
    if (rst) begin
      busAck <= 1'b0;
      ackArmed = 1'b0;
    end else if (busAck) begin
      // request drops on this edge
      busAck <= 1'b0;
    end else if (fetchLine || writeLine) begin
      if (!ackArmed) begin
        ackArmed = 1'b1;
        ackLeft = ackDelays[ackPick % 64];
        ackPick++;
      end
      if (ackLeft == 0) begin
        ackArmed = 1'b0;
        busAck <= 1'b1;
        baseWord = int'(lineAdr) >> 2;
        for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
          if (writeLine) begin
            memWords[baseWord + w] = lineWriteData[w*`DC_XLEN +: `DC_XLEN];
          end else begin
            lineReadData[w*`DC_XLEN +: `DC_XLEN] <= memWords[baseWord + w];
          end
        end
      end else begin
        ackLeft--;
      end
    end
  end

  // miss pulses seen, compared per step
  always @(posedge clk) begin
    if (!rst && miss) begin
      missCount <= missCount + 1;
    end
  end

  // run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
      $display("timeout: no respDone or flushDone within %0d cycles", cycleLimit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // table and steps
  ////////////////////////////////////////////////////////////////////////////

  task automatic addStep(input string name, input int kind, input paddrT adr,
                         input wordT data, input int expMiss);
    stepName.push_back(name);
    stepKind.push_back(kind);
    stepAdr.push_back(adr);
    stepData.push_back(data);
    stepMiss.push_back(expMiss);
  endtask

  function automatic int countMemMismatches();
    int bad;
    bad = 0;
    for (int i = 0; i < MemWords; i++) begin
      if (memWords[i] !== refWords[i]) bad++;
    end
    return bad;
  endfunction

  // busy as it stood in the cycle that just ended
  task automatic checkBusy(input int idx, input logic expBusy, inout bit ok);
    assert (busy === expBusy) else begin
      $display("FAIL %s busy expected %b actual %b", stepName[idx], expBusy, busy);
      ok = 1'b0;
    end
  endtask

  task automatic runStep(input int idx);
    int   missBefore;
    int   badWords;
    int   wordIdx;
    bit   stepOk;
    wordT expData;
    missBefore = missCount;
    stepOk = 1'b1;
    wordIdx = int'(stepAdr[idx]) >> 2;
    if (stepKind[idx] == KindFlush) begin
      flushReq <= 1'b1;
      @(posedge clk);
      flushReq <= 1'b0;
      @(posedge clk);
      // walk has started
      checkBusy(idx, 1'b1, stepOk);
      while (!flushDone) @(posedge clk);
      checkBusy(idx, 1'b0, stepOk);
      // every dirty line must have reached memory
      badWords = countMemMismatches();
      assert (badWords == 0) else begin
        $display("FAIL %s expected 0 stale words actual %0d", stepName[idx], badWords);
        stepOk = 1'b0;
      end
    end else begin
      if (stepKind[idx] == KindWrite) begin
        refWords[wordIdx] = stepData[idx];
      end
      expData = refWords[wordIdx];
      reqValid     <= 1'b1;
      reqOp        <= (stepKind[idx] == KindWrite) ? opWrite : opRead;
      reqAdr       <= stepAdr[idx];
      reqWriteData <= stepData[idx];
      @(posedge clk);
      reqValid <= 1'b0;
      @(posedge clk);
      // lookup cycle after the capture
      checkBusy(idx, 1'b1, stepOk);
      while (!respDone) @(posedge clk);
      checkBusy(idx, 1'b0, stepOk);
      if (stepKind[idx] == KindRead) begin
        assert (readData === expData) else begin
          $display("FAIL %s expected %h actual %h", stepName[idx], expData, readData);
          stepOk = 1'b0;
        end
      end
    end
    assert (missCount - missBefore == stepMiss[idx]) else begin
      $display("FAIL %s miss count expected %0d actual %0d", stepName[idx],
               stepMiss[idx], missCount - missBefore);
      stepOk = 1'b0;
    end
    if (stepOk) passCount++;
    else failCount++;
    $display("%-6s %s", stepOk ? "ok" : "bad", stepName[idx]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'head2_4162));
    for (int i = 0; i < 64; i++) begin
      ackDelays[i] = $urandom % 4;
    end
    for (int i = 0; i < MemWords; i++) begin
      memWords[i] = fillWord(i);
      refWords[i] = fillWord(i);
    end
    rst = 1'b1;
    reqValid = 1'b0;
    reqOp = opNone;
    reqAdr = '0;
    reqWriteData = '0;
    flushReq = 1'b0;
    busAck = 1'b0;
    lineReadData = '0;

    // set 0 takes tags 2, 3 and 4, set 3 tags 0 and 1, set 7 tag 0xff
    addStep("rdA0",   KindRead,  16'h0100, '0,           1);
    addStep("rdA1",   KindRead,  16'h0104, '0,           0);
    addStep("wrA2",   KindWrite, 16'h0108, 32'hdeadbeef, 0);
    addStep("rdA2",   KindRead,  16'h0108, '0,           0);
    addStep("rdB0",   KindRead,  16'h0180, '0,           1);
    addStep("wrB1",   KindWrite, 16'h0184, 32'h12345678, 0);
    // third tag in set 0 evicts dirty A from way 0
    addStep("rdC0",   KindRead,  16'h0200, '0,           1);
    addStep("rdA2b",  KindRead,  16'h0108, '0,           1);
    addStep("rdB1",   KindRead,  16'h0184, '0,           1);
    addStep("wrS1",   KindWrite, 16'h0034, 32'hcafef00d, 1);
    addStep("wrS2",   KindWrite, 16'h00b8, 32'h0badc0de, 1);
    addStep("wrB2",   KindWrite, 16'h0188, 32'h55aa55aa, 0);
    addStep("rdS1",   KindRead,  16'h0034, '0,           0);
    addStep("flush",  KindFlush, 16'h0000, '0,           0);
    // flushed lines stay valid
    addStep("rdS2",   KindRead,  16'h00b8, '0,           0);
    addStep("rdB2",   KindRead,  16'h0188, '0,           0);
    addStep("rdW",    KindRead,  16'h7ff0, '0,           1);

    cycleLimit = 40 * stepName.size() + 8;
    foreach (stepKind[i]) begin
      if (stepKind[i] == KindFlush) cycleLimit += 400;
    end

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < stepName.size(); i++) begin
      runStep(i);
    end

    $display("steps %0d, passed %0d, failed %0d", stepName.size(), passCount, failCount);
    if (failCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache_props.sv
// concurrent assertions on the bus and CPU handshakes and the controller, bound into dcache
`timescale 1ns/1ps
`default_nettype none

module dcacheProps (
  input logic                   clk,
  input logic                   rst,
  input logic                   reqValid,
  input logic                   busy,
  input logic                   respDone,
  input logic                   flushDone,
  input logic                   fetchLine,
  input logic                   writeLine,
  input logic                   busAck,
  input dcacheCtrlPkg::dcStateT state
);
  import dcacheCtrlPkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // memory side
  ////////////////////////////////////////////////////////////////////////////

  // one line transfer at a time
  assert property (@(posedge clk) disable iff (rst) !(fetchLine && writeLine))
    else $error("fetchLine and writeLine high together");

  // requests hold until acknowledged
  assert property (@(posedge clk) disable iff (rst) fetchLine && !busAck |=> fetchLine)
    else $error("fetchLine dropped before busAck");
  assert property (@(posedge clk) disable iff (rst) writeLine && !busAck |=> writeLine)
    else $error("writeLine dropped before busAck");

  ////////////////////////////////////////////////////////////////////////////
  // cpu side and controller
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (rst) respDone |=> !respDone)
    else $error("respDone longer than one cycle");
  assert property (@(posedge clk) disable iff (rst) flushDone |=> !flushDone)
    else $error("flushDone longer than one cycle");

  // no back-pressure, so the cpu has to wait for busy low
  assert property (@(posedge clk) disable iff (rst) reqValid |-> !busy)
    else $error("reqValid while busy");

  // the refilled line has to hit on replay
  assert property (@(posedge clk) disable iff (rst) state == stReplay |=> respDone)
    else $error("replay after refill did not hit");

endmodule

bind dcache dcacheProps uProps (
  .clk, .rst, .reqValid, .busy, .respDone, .flushDone,
  .fetchLine, .writeLine, .busAck,
  .state (uFsm.state)
);

`default_nettype wire

//--- dcache.sv
// data cache top: request registers, ways, LRU, flush counters and datapath muxes
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache (
  input  logic                     clk,
  input  logic                     rst,
  // cpu side
  input  logic                     reqValid,
  input  dcacheCpuPkg::memOpT      reqOp,
  input  dcacheCpuPkg::paddrT      reqAdr,
  input  dcacheCpuPkg::wordT       reqWriteData,
  input  logic                     flushReq,
  output dcacheCpuPkg::wordT       readData,
  output logic                     respDone,
  output logic                     busy,
  output logic                     miss,
  output logic                     flushDone,
  // memory side
  output dcacheCpuPkg::paddrT      lineAdr,
  output logic [`DC_LINE_BITS-1:0] lineWriteData,
  output logic                     fetchLine,
  output logic                     writeLine,
  input  logic [`DC_LINE_BITS-1:0] lineReadData,
  input  logic                     busAck
);
  import dcacheCpuPkg::*;
  import dcacheCtrlPkg::*;

  localparam int ByteBits = $clog2(`DC_XLEN / 8);
  localparam int WordBits = `DC_OFFSET_BITS - ByteBits;

  memOpT                    reqOpQ;
  paddrT                    reqAdrQ;
  wordT                     reqDataQ;
  logic [`DC_INDEX_BITS-1:0] reqIndex, rdIndex, wrIndex, flushSet;
  logic [`DC_TAG_BITS-1:0]  reqTag, selTag;
  logic [WordBits-1:0]      wordIdx;
  logic [`DC_WORDS_PER_LINE-1:0] wordSel;
  logic [`DC_NUM_WAYS-1:0]  wayHit, wayDirty, wayValid, victimWay, flushWay;
  logic [`DC_LINE_BITS-1:0] wayLine [`DC_NUM_WAYS];
  logic [`DC_TAG_BITS-1:0]  wayTag  [`DC_NUM_WAYS];
  logic [`DC_LINE_BITS-1:0] selLine, wayWriteData;
  logic [1:0]               selAdr;
  logic cacheHit, victimDirty, flushSlotDirty, flushLast;
  logic lruUpdate, flushAdvance, flushClear, captureReq;

  wayCtrlIf wayIf ();

  ////////////////////////////////////////////////////////////////////////////
  // request capture and address fields
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (captureReq) begin
      reqOpQ   <= reqOp;
      reqAdrQ  <= reqAdr;
      reqDataQ <= reqWriteData;
    end
  end

  assign reqTag   = reqAdrQ[`DC_PA_BITS-1 -: `DC_TAG_BITS];
  assign reqIndex = reqAdrQ[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
  assign wordIdx  = reqAdrQ[ByteBits +: WordBits];
  assign wordSel  = `DC_WORDS_PER_LINE'(1) << wordIdx;

  // flush walk reads and writes at the flush set
  assign rdIndex = selAdr[1] ? flushSet : reqIndex;
  assign wrIndex = wayIf.selFlush ? flushSet : reqIndex;

  ////////////////////////////////////////////////////////////////////////////
  // flush counters, index-major and way-minor
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || flushClear) begin
      flushSet <= '0;
      flushWay <= 2'b01;
    end else if (flushAdvance) begin
      flushWay <= {flushWay[0], flushWay[1]};
      if (flushWay[1]) begin
        flushSet <= flushSet + 1'b1;
      end
    end
  end

  assign flushLast = (flushSet == `DC_INDEX_BITS'(`DC_NUM_SETS - 1)) && flushWay[1];

  ////////////////////////////////////////////////////////////////////////////
  // ways and replacement
  ////////////////////////////////////////////////////////////////////////////

  // flush way, hit way on a hit, otherwise the lru victim
  assign wayIf.wayWriteSel = wayIf.selFlush ? flushWay : (cacheHit ? wayHit : victimWay);

  // refill takes the bus line, a store the word copied to every slot
  assign wayWriteData = (wayIf.wayWriteMode == wwLine) ? lineReadData
                                                       : {`DC_WORDS_PER_LINE{reqDataQ}};

  for (genvar g = 0; g < `DC_NUM_WAYS; g++) begin : gWay
    cacheWay uWay (
      .clk, .rst, .rdIndex, .wrIndex, .reqTag, .wordSel,
      .wayEn     (wayIf.wayWriteSel[g]),
      .writeData (wayWriteData),
      .ctl       (wayIf),
      .hit       (wayHit[g]),
      .lineData  (wayLine[g]),
      .victimTag (wayTag[g]),
      .dirty     (wayDirty[g]),
      .valid     (wayValid[g])
    );
  end

  lruPolicy uLru (
    .clk, .rst, .victimWay,
    .index  (reqIndex),
    .hitWay (wayHit),
    .update (lruUpdate)
  );

  assign cacheHit       = |wayHit;
  assign victimDirty    = |wayDirty;
  assign flushSlotDirty = |(wayDirty & wayValid);

  // ways are already masked, OR them down
  always_comb begin
    selLine = '0;
    selTag  = '0;
    for (int w = 0; w < `DC_NUM_WAYS; w++) begin
      selLine |= wayLine[w];
      selTag  |= wayTag[w];
    end
  end

  // read word held until the next hit
  always_ff @(posedge clk) begin
    if (lruUpdate) begin
      readData <= selLine[wordIdx*`DC_XLEN +: `DC_XLEN];
    end
  end

  // line address for the bus
  always_comb begin
    case (selAdr)
      2'b01:   lineAdr = {selTag, reqIndex, `DC_OFFSET_BITS'(0)};
      2'b10:   lineAdr = {selTag, flushSet, `DC_OFFSET_BITS'(0)};
      default: lineAdr = {reqTag, reqIndex, `DC_OFFSET_BITS'(0)};
    endcase
  end

  assign lineWriteData = selLine;

  ////////////////////////////////////////////////////////////////////////////
  // controller
  ////////////////////////////////////////////////////////////////////////////

  dcacheFsm uFsm (
    .clk, .rst, .reqValid, .flushReq, .cacheHit, .victimDirty,
    .flushSlotDirty, .flushLast, .busAck, .selAdr, .lruUpdate,
    .flushAdvance, .flushClear, .fetchLine, .writeLine, .busy,
    .respDone, .miss, .flushDone, .captureReq,
    .reqOp (reqOpQ),
    .ctl   (wayIf)
  );

endmodule

`default_nettype wire

//--- dcacheFsm.sv
// cache controller FSM: lookup, writeback, fetch, refill, replay and flush walk
`timescale 1ns/1ps
`default_nettype none

module dcacheFsm (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 reqValid,
  input  dcacheCpuPkg::memOpT  reqOp,
  input  logic                 flushReq,
  input  logic                 cacheHit,
  input  logic                 victimDirty,
  input  logic                 flushSlotDirty,
  input  logic                 flushLast,
  input  logic                 busAck,
  wayCtrlIf.ctrl               ctl,
  output logic [1:0]           selAdr,
  output logic                 lruUpdate,
  output logic                 flushAdvance,
  output logic                 flushClear,
  output logic                 fetchLine,
  output logic                 writeLine,
  output logic                 busy,
  output logic                 respDone,
  output logic                 miss,
  output logic                 flushDone,
  output logic                 captureReq
);
  import dcacheCpuPkg::*;
  import dcacheCtrlPkg::*;

  dcStateT state;
  dcStateT nextState;
  logic    ready;
  logic    isStore;
  logic    hitDone;
  logic    flushing;

  ////////////////////////////////////////////////////////////////////////////
  // state register and next state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stIdle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      // flush done cycle accepts new work like idle
      stIdle, stFlushDone: begin
        if (flushReq) begin
          nextState = stFlushCheck;
        end else if (reqValid) begin
          nextState = stLookup;
        end else begin
          nextState = stIdle;
        end
      end
      stLookup: begin
        if (cacheHit) begin
          nextState = stIdle;
        end else if (victimDirty) begin
          nextState = stWriteBack;
        end else begin
          nextState = stFetch;
        end
      end
      // victim line out, then new line in
      stWriteBack: if (busAck) nextState = stFetch;
      stFetch:     if (busAck) nextState = stRefill;
      stRefill:    nextState = stReplay;
      // replay should always hit, else look up again
      stReplay:    nextState = cacheHit ? stIdle : stLookup;
      stFlushCheck: nextState = flushSlotDirty ? stFlushWrite : stFlushNext;
      stFlushWrite: if (busAck) nextState = stFlushNext;
      stFlushNext:  nextState = flushLast ? stFlushDone : stFlushCheck;
      default:      nextState = stIdle;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  assign ready    = (state == stIdle) || (state == stFlushDone);
  assign isStore  = (reqOp == opWrite);
  assign hitDone  = ((state == stLookup) || (state == stReplay)) && cacheHit;
  assign flushing = (state == stFlushCheck) || (state == stFlushWrite) ||
                    (state == stFlushNext);

  // cpu handshake
  assign captureReq = ready && reqValid && !flushReq;
  assign busy       = !ready;
  assign miss       = (state == stLookup) && !cacheHit;
  assign flushDone  = (state == stFlushDone);
  assign lruUpdate  = hitDone;

  // respDone lands one cycle after the hit, when state is back in idle
  always_ff @(posedge clk) begin
    if (rst) begin
      respDone <= 1'b0;
    end else begin
      respDone <= hitDone;
    end
  end

  // bus requests, held until busAck
  assign writeLine = (state == stWriteBack) || (state == stFlushWrite);
  assign fetchLine = (state == stFetch);

  // flush counters
  assign flushClear   = ready && flushReq;
  assign flushAdvance = (state == stFlushNext) && !flushLast;

  // 2'b10 flush index/tag, 2'b01 victim tag, 2'b00 request line
  assign selAdr = flushing ? 2'b10 : ((state == stWriteBack) ? 2'b01 : 2'b00);

  // way controls
  // line arrives on the busAck edge, valid and dirty settle a cycle later
  assign ctl.wayWriteMode = (hitDone && isStore) ? wwWord :
                            ((state == stFetch) && busAck) ? wwLine : wwNone;
  assign ctl.setDirty     = hitDone && isStore;
  assign ctl.setValid     = (state == stRefill);
  assign ctl.clearDirty   = (state == stRefill) || ((state == stFlushWrite) && busAck);
  assign ctl.selFlush     = flushing;

endmodule

`default_nettype wire

//--- lruPolicy.sv
// one-bit-per-set LRU array and victim way selection
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module lruPolicy (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`DC_INDEX_BITS-1:0] index,
  input  logic [`DC_NUM_WAYS-1:0]   hitWay,
  input  logic                      update,
  output logic [`DC_NUM_WAYS-1:0]   victimWay
);

  // bit set means way 1 is least recently used
  logic [`DC_NUM_SETS-1:0] lruBits;

  always_ff @(posedge clk) begin
    if (rst) begin
      lruBits <= '0;
    end else if (update) begin
      // point at the way that was not touched
      lruBits[index] <= hitWay[0];
    end
  end

  // victim one-hot for the current set
  assign victimWay = lruBits[index] ? 2'b10 : 2'b01;

endmodule

`default_nettype wire

//--- cacheWay.sv
// one cache way: data, tag, valid and dirty arrays with tag compare
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module cacheWay (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`DC_INDEX_BITS-1:0]    rdIndex,
  input  logic [`DC_INDEX_BITS-1:0]    wrIndex,
  input  logic [`DC_TAG_BITS-1:0]      reqTag,
  input  logic [`DC_WORDS_PER_LINE-1:0] wordSel,
  input  logic                         wayEn,
  input  logic [`DC_LINE_BITS-1:0]     writeData,
  wayCtrlIf.way                        ctl,
  output logic                         hit,
  output logic [`DC_LINE_BITS-1:0]     lineData,
  output logic [`DC_TAG_BITS-1:0]      victimTag,
  output logic                         dirty,
  output logic                         valid
);
  import dcacheCpuPkg::*;
  import dcacheCtrlPkg::*;

  logic [`DC_LINE_BITS-1:0]     lineArr [`DC_NUM_SETS];
  logic [`DC_TAG_BITS-1:0]      tagArr  [`DC_NUM_SETS];
  logic [`DC_NUM_SETS-1:0]      validArr;
  logic [`DC_NUM_SETS-1:0]      dirtyArr;
  logic [`DC_WORDS_PER_LINE-1:0] wordEn;
  wordT                         wrWords [`DC_WORDS_PER_LINE];

  // line mode enables every word, word mode only the addressed one
  assign wordEn = (ctl.wayWriteMode == wwLine) ? '1 : wordSel;

  always_comb begin
    for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
      wrWords[w] = writeData[w*`DC_XLEN +: `DC_XLEN];
    end
  end

  // data and tag, no reset
  always_ff @(posedge clk) begin
    if (wayEn && (ctl.wayWriteMode != wwNone)) begin
      for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
        if (wordEn[w]) begin
          lineArr[wrIndex][w*`DC_XLEN +: `DC_XLEN] <= wrWords[w];
        end
      end
    end
    // tag only changes on a refill
    if (wayEn && (ctl.wayWriteMode == wwLine)) begin
      tagArr[wrIndex] <= reqTag;
    end
  end

  // valid and dirty bits
  always_ff @(posedge clk) begin
    if (rst) begin
      validArr <= '0;
      dirtyArr <= '0;
    end else if (wayEn) begin
      if (ctl.setValid) begin
        validArr[wrIndex] <= 1'b1;
      end
      // a store wins over a clear
      if (ctl.setDirty) begin
        dirtyArr[wrIndex] <= 1'b1;
      end else if (ctl.clearDirty) begin
        dirtyArr[wrIndex] <= 1'b0;
      end
    end
  end

  // tag compare, blocked while flushing so the walk owns the way select
  assign hit = validArr[rdIndex] && (tagArr[rdIndex] == reqTag) && !ctl.selFlush;

  // outputs masked by way select, top ORs the ways together
  assign lineData  = wayEn ? lineArr[rdIndex] : '0;
  assign victimTag = wayEn ? tagArr[rdIndex] : '0;
  assign dirty     = wayEn & dirtyArr[rdIndex];
  assign valid     = wayEn & validArr[rdIndex];

endmodule

`default_nettype wire

//--- wayCtrlIf.sv
// interface carrying controller and datapath write controls to the cache ways
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

interface wayCtrlIf;
  import dcacheCtrlPkg::*;

  // data array write mode, from the fsm
  wayWriteT wayWriteMode;

  // one-hot way select, built in the datapath from hit, victim or flush way
  logic [`DC_NUM_WAYS-1:0] wayWriteSel;

  // valid/dirty updates on the selected way
  logic setDirty;
  logic clearDirty;
  logic setValid;

  // flush walk is running
  logic selFlush;

  modport ctrl (
    output wayWriteMode, setDirty, clearDirty, setValid, selFlush
  );

  modport dpath (
    input  wayWriteMode, selFlush,
    output wayWriteSel
  );

  // wayWriteSel reaches each way as its own wayEn bit
  modport way (
    input wayWriteMode, setDirty, clearDirty, setValid, selFlush
  );

endinterface

`default_nettype wire

//--- dcacheCtrlPkg.sv
// controller types: FSM state enum and way write-mode enum
`default_nettype none

package dcacheCtrlPkg;

  // controller states
  typedef enum logic [3:0] {
    stIdle       = 4'd0,
    stLookup     = 4'd1,
    stWriteBack  = 4'd2,
    stFetch      = 4'd3,
    stRefill     = 4'd4,
    stReplay     = 4'd5,
    stFlushCheck = 4'd6,
    stFlushWrite = 4'd7,
    stFlushNext  = 4'd8,
    stFlushDone  = 4'd9
  } dcStateT;

  // how the selected way writes its data array
  // wwWord touches one word, wwLine the full line plus tag
  typedef enum logic [1:0] {
    wwNone = 2'd0,
    wwWord = 2'd1,
    wwLine = 2'd2
  } wayWriteT;

endpackage

`default_nettype wire

//--- dcacheCpuPkg.sv
// CPU-side types: word and physical address types, memory-operation enum
`default_nettype none

`include "dcache_cfg.svh"

package dcacheCpuPkg;

  // one core word
  typedef logic [`DC_XLEN-1:0] wordT;

  // physical address as seen by the cache
  // tag | index | word offset | byte offset
  typedef logic [`DC_PA_BITS-1:0] paddrT;

  // cpu request kind
  // opNone is treated like a read if it ever gets strobed
  typedef enum logic [1:0] {
    opNone  = 2'd0,
    opRead  = 2'd1,
    opWrite = 2'd2
  } memOpT;

endpackage

`default_nettype wire

//--- dcache_cfg.svh
// size macros for the L1 data cache: word, address, line, set and way geometry
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// base sizes
////////////////////////////////////////////////////////////////////////////

// core word and physical address
`define DC_XLEN 32
`define DC_PA_BITS 16

// one line is four words
`define DC_LINE_BITS 128
`define DC_NUM_SETS 8

// lru is one bit per set, so two ways only
`define DC_NUM_WAYS 2

////////////////////////////////////////////////////////////////////////////
// derived sizes
////////////////////////////////////////////////////////////////////////////

`define DC_WORDS_PER_LINE (`DC_LINE_BITS / `DC_XLEN)
`define DC_OFFSET_BITS $clog2(`DC_LINE_BITS / 8)
`define DC_INDEX_BITS $clog2(`DC_NUM_SETS)
`define DC_TAG_BITS (`DC_PA_BITS - `DC_OFFSET_BITS - `DC_INDEX_BITS)

`endif
